// File: src.f
verilog/calc_pkg.sv
verilog/key_event_if.sv
verilog/debounce_timer.sv
verilog/input_control.sv
verilog/calc_core.sv
verilog/keypad_calc_top.sv
verif/keypad_model.sv
verif/tb_keypad_calc.sv

// File: run.sh
#!/bin/sh
# build and run the keypad calculator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_keypad_calc
output=$(./obj_dir/Vtb_keypad_calc)
echo "$output"
if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

// File: verif/tb_keypad_calc.sv
`timescale 1ns/10ps

module tb_keypad_calc;

    localparam int DEBOUNCE = 10;
    localparam int WIDTH    = 16;
    localparam int TIMEOUT  = 2000;             // cycles per wait

    logic             clk;
    logic             nRST;
    logic [3:0]       RowIn;
    logic [3:0]       ColOut;
    logic [WIDTH-1:0] entry;
    logic [WIDTH-1:0] result;
    logic             result_valid;
    logic             pressed;                  // switch contact
    logic [3:0]       key_idx;                  // key under the finger
    int               history[$];               // every key since reset
    int               seq[$];
    logic [WIDTH-1:0] exp_entry;
    logic [WIDTH-1:0] exp_result;
    logic             check_entry;              // one-cycle compare request
    int               valid_seen;               // result_valid pulses counted
    int               valid_expected;
    int               value_errors;
    int               timeout_errors;
    int               len;

    keypad_calc_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE),
        .WIDTH          (WIDTH)
    ) uut (
        .clk         (clk),
        .nRST        (nRST),
        .RowIn       (RowIn),
        .ColOut      (ColOut),
        .entry       (entry),
        .result      (result),
        .result_valid(result_valid)
    );

    keypad_model u_keypad_model (
        .ColOut (ColOut),
        .pressed(pressed),
        .key_idx(key_idx),
        .RowIn  (RowIn)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    // digit on the key face or -1 for keys without one
    function automatic int digit_of(input int k);
        if (k <= 2) return k + 1;
        if (k >= 4 && k <= 6) return k;
        if (k >= 8 && k <= 10) return k - 1;
        if (k == 13) return 0;
        return -1;
    endfunction

    // expected entry and result evaluated strictly left to right with wrap at WIDTH
    function automatic void calc_ref(input int keys[$], output logic [WIDTH-1:0] e,
                                     output logic [WIDTH-1:0] r);
        logic [WIDTH-1:0] acc;
        calc_pkg::op_t    pend;
        calc_pkg::op_t    op;
        logic             is_eq;
        e    = '0;
        r    = '0;
        acc  = '0;
        pend = calc_pkg::OP_NONE;
        foreach (keys[i]) begin
            op    = calc_pkg::OP_NONE;
            is_eq = (keys[i] == int'(calc_pkg::KEY_EQUAL));
            if (keys[i] == 3) op = calc_pkg::OP_ADD;
            if (keys[i] == 7) op = calc_pkg::OP_SUB;
            if (keys[i] == 11) op = calc_pkg::OP_MUL;
            if (digit_of(keys[i]) >= 0) e = e * WIDTH'(10) + WIDTH'(digit_of(keys[i]));
            if (keys[i] == int'(calc_pkg::KEY_NEG)) e = -e;
            if (is_eq || (op != calc_pkg::OP_NONE)) begin
                case (pend)
                    calc_pkg::OP_ADD: acc = acc + e;
                    calc_pkg::OP_SUB: acc = acc - e;
                    calc_pkg::OP_MUL: acc = acc * e;
                    default:          acc = e;  // first operand
                endcase
                pend = op;                      // equal leaves none pending
                e    = '0;
                if (is_eq) r = acc;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [WIDTH-1:0] got,
                               input logic [WIDTH-1:0] exp);
        assert (got == exp) else begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // compare process reads values settled since the last edge
    always @(posedge clk) begin
        if (check_entry) check_value("entry", entry, exp_entry);
        if (result_valid) begin
            valid_seen++;
            check_value("result", result, exp_result);
        end
    end

    task automatic check_pulses();
        check_value("result_valid count", WIDTH'(valid_seen), WIDTH'(valid_expected));
    endtask

    // contact chatter with every closure shorter than the debounce time
    task automatic bounce(input int glitches);
        repeat (glitches) begin
            pressed = ~pressed;
            repeat ($urandom_range(DEBOUNCE - 3, 1)) @(negedge clk);
            pressed = ~pressed;
            repeat ($urandom_range(3, 1)) @(negedge clk);
        end
    endtask

    task automatic press_key(input int idx, input int bounce_in, input int bounce_out);
        logic [WIDTH-1:0] e;
        logic [WIDTH-1:0] r;
        int               cycles;
        history.push_back(idx);
        calc_ref(history, e, r);
        exp_result = r;
        key_idx    = 4'(idx);
        pressed    = 1'b0;
        bounce(bounce_in);
        pressed = 1'b1;
        if (idx == int'(calc_pkg::KEY_BLANK)) begin
            repeat (4 * DEBOUNCE) @(negedge clk);   // confirmed but raises no event
        end else begin
            cycles = 0;
            while (uut.key_ev.key_read !== 1'b1 && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (uut.key_ev.key_read !== 1'b1) begin
                $display("Key %0d was not accepted within %0d cycles", idx, TIMEOUT);
                timeout_errors++;
            end
        end
        exp_entry   = e;
        check_entry = 1'b1;
        @(negedge clk);
        check_entry = 1'b0;
        if (idx == int'(calc_pkg::KEY_EQUAL)) begin
            valid_expected++;
            cycles = 0;
            while (valid_seen < valid_expected && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (valid_seen < valid_expected) begin
                $display("No result_valid pulse after the equal key");
                timeout_errors++;
            end
        end
        pressed = 1'b1;
        bounce(bounce_out);                     // glitch back on during release
        pressed = 1'b0;
        repeat (2 * DEBOUNCE + 6) @(negedge clk);   // release debounce
    endtask

    // short closure that must never turn into a key
    task automatic glitch_key(input int idx);
        key_idx = 4'(idx);
        pressed = 1'b1;
        repeat ($urandom_range(DEBOUNCE - 3, 1)) @(negedge clk);
        pressed = 1'b0;
        repeat (2 * DEBOUNCE + 6) @(negedge clk);
    endtask

    initial begin
        void'($urandom(63695));
        nRST           = 1'b0;
        pressed        = 1'b0;
        key_idx        = 4'd0;
        check_entry    = 1'b0;
        exp_entry      = '0;
        exp_result     = '0;
        valid_seen     = 0;
        valid_expected = 0;
        value_errors   = 0;
        timeout_errors = 0;
        repeat (10) @(negedge clk);
        check_value("ColOut", WIDTH'(ColOut), WIDTH'(4'b1110));    // column 0 low in reset
        nRST = 1'b1;
        @(negedge clk);
        check_value("result_valid", WIDTH'(result_valid), '0);
        check_value("entry", entry, '0);
        check_value("result", result, '0);
        seq = {0, 1, 2, 4, 5, 6, 8, 9, 10, 13, 12};     // all ten digits then equal
        foreach (seq[i]) press_key(seq[i], 2, 2);
        seq = {0, 1, 3, 2, 4, 7, 5, 11, 6, 12};         // 12+34-5*6=
        foreach (seq[i]) press_key(seq[i], 1, 1);
        seq = {10, 10, 10, 11, 10, 10, 10, 12, 2, 7, 8, 12};    // wraps both ways
        foreach (seq[i]) press_key(seq[i], 0, 1);
        seq = {5, 8, 15, 3, 2, 12};                     // -57+3=
        foreach (seq[i]) press_key(seq[i], 1, 0);
        check_pulses();
        press_key(4, 0, 0);
        press_key(int'(calc_pkg::KEY_BLANK), 1, 1);
        glitch_key(5);
        glitch_key(int'(calc_pkg::KEY_EQUAL));
        glitch_key(3);
        check_value("entry", entry, exp_entry);         // expect both unchanged
        check_value("result", result, exp_result);
        check_pulses();
        press_key(int'(calc_pkg::KEY_EQUAL), 0, 0);
        repeat (40) begin
            len = int'($urandom_range(6, 1));
            repeat (len) press_key($urandom_range(15, 0), $urandom_range(2, 0),
                                   $urandom_range(2, 0));
            press_key(int'(calc_pkg::KEY_EQUAL), 0, 0);
        end
        check_pulses();
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verif/keypad_model.sv
`timescale 1ns/10ps

module keypad_model (
    input  logic [calc_pkg::NUM_COLS-1:0] ColOut,   // active low column drive from uut
    input  logic                          pressed,  // contact closed, bounce comes from tb
    input  logic [3:0]                    key_idx,  // row * NUM_COLS + col
    output logic [calc_pkg::NUM_ROWS-1:0] RowIn     // pulled up rows
);

    // a closed switch shorts its row to its column
    always_comb begin
        RowIn = '1;                                 // pull-ups
        for (int r = 0; r < calc_pkg::NUM_ROWS; r++) begin
            for (int c = 0; c < calc_pkg::NUM_COLS; c++) begin
                if (pressed && (key_idx == 4'(r * calc_pkg::NUM_COLS + c)) && !ColOut[c]) begin
                    RowIn[r] = 1'b0;                // row follows the low column
                end
            end
        end
    end

endmodule

// File: verilog/keypad_calc_top.sv
`timescale 1ns/10ps

module keypad_calc_top #(
    parameter int DEBOUNCE_CYCLES = 10,     // press and release steady time
    parameter int WIDTH           = 16      // calculator word
) (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [calc_pkg::NUM_ROWS-1:0] RowIn,
    output logic [calc_pkg::NUM_COLS-1:0] ColOut,
    output logic [WIDTH-1:0]              entry,
    output logic [WIDTH-1:0]              result,
    output logic                          result_valid
);

    key_event_if key_ev ();     // scanner to controller events

    input_control #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_input_control (
        .clk   (clk),
        .nRST  (nRST),
        .RowIn (RowIn),
        .ColOut(ColOut),
        .ev    (key_ev.scanner)
    );

    calc_core #(
        .WIDTH(WIDTH)
    ) u_calc_core (
        .clk         (clk),
        .nRST        (nRST),
        .ev          (key_ev.controller),
        .entry       (entry),
        .result      (result),
        .result_valid(result_valid)
    );

endmodule

// File: verilog/calc_core.sv
`timescale 1ns/10ps

module calc_core #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    key_event_if.controller  ev,
    output logic [WIDTH-1:0] entry,         // number being typed
    output logic [WIDTH-1:0] result,        // last equal value
    output logic             result_valid   // pulse with equal take
);

    logic [WIDTH-1:0] acc;          // left-to-right running value
    calc_pkg::op_t    pending;      // operator waiting for its rhs
    logic             accept;       // take event this edge
    logic [WIDTH-1:0] entry_x10;
    logic [WIDTH-1:0] step;         // acc after pending op

    // arithmetic wraps at WIDTH bits
    function automatic logic [WIDTH-1:0] apply_op(
        input calc_pkg::op_t    op,
        input logic [WIDTH-1:0] lhs,
        input logic [WIDTH-1:0] rhs
    );
        case (op)
            calc_pkg::OP_ADD: return lhs + rhs;
            calc_pkg::OP_SUB: return lhs - rhs;
            calc_pkg::OP_MUL: return lhs * rhs;
            default:          return rhs;       // no pending op, entry starts chain
        endcase
    endfunction

    assign accept    = ev.read_input && !ev.key_read;  // first cycle seen high
    assign entry_x10 = (entry << 3) + (entry << 1);    // entry * 10
    assign step      = apply_op(pending, acc, entry);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            ev.key_read  <= 1'b0;
            entry        <= '0;
            acc          <= '0;
            pending      <= calc_pkg::OP_NONE;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            ev.key_read  <= accept;                     // exactly one cycle
            result_valid <= accept && ev.equal_input;
            if (accept) begin
                if (ev.equal_input) begin
                    acc     <= step;
                    result  <= step;                    // held until next equal
                    pending <= calc_pkg::OP_NONE;
                    entry   <= '0;
                end else begin
                    case (ev.operator_input)
                        calc_pkg::OP_NONE: begin
                            entry <= entry_x10 + WIDTH'(ev.keypad_input);  // append digit
                        end
                        calc_pkg::OP_NEG: begin
                            entry <= -entry;            // two's complement
                        end
                        default: begin
                            acc     <= step;            // fold entry into acc
                            pending <= ev.operator_input;
                            entry   <= '0;
                        end
                    endcase
                end
            end
        end
    end

endmodule

// File: verilog/input_control.sv
`timescale 1ns/10ps

module input_control #(
    parameter int DEBOUNCE_CYCLES = 10
) (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [calc_pkg::NUM_ROWS-1:0] RowIn,    // pulled up, low when pressed
    output logic [calc_pkg::NUM_COLS-1:0] ColOut,   // active low column drive
    key_event_if.scanner                  ev
);

    localparam int COL_W = $clog2(calc_pkg::NUM_COLS);

    typedef enum logic [2:0] {
        SCAN,           // walk columns until a row drops
        WAIT_STABLE,    // press debounce
        CONFIRM,        // encode and decode key
        WAIT_EVENT,     // read_input up, wait key_read
        WAIT_RELEASE    // release debounce
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [COL_W-1:0] col_index;    // column driven low
    logic             any_low;      // some row pulled low
    logic             timer_clear;
    logic             steady;
    logic [3:0]       key_idx;      // row * NUM_COLS + col
    logic [3:0]       dec_digit;
    calc_pkg::op_t    dec_op;
    logic             dec_equal;
    logic             dec_blank;    // key with no meaning

    assign any_low     = ~&RowIn;
    assign timer_clear = (state == SCAN);   // count starts with the press

    debounce_timer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_debounce_timer (
        .clk   (clk),
        .nRST  (nRST),
        .clear (timer_clear),
        .level (any_low),
        .steady(steady)
    );

    always_comb begin
        ColOut            = '1;
        ColOut[col_index] = 1'b0;   // one column low at a time
    end

    // lowest low row wins, so walk rows from the top down
    always_comb begin
        key_idx = calc_pkg::KEY_BLANK;  // row gone, treat as blank
        for (int r = calc_pkg::NUM_ROWS - 1; r >= 0; r--) begin
            if (!RowIn[r]) begin
                key_idx = 4'(r * calc_pkg::NUM_COLS) + 4'(col_index);
            end
        end
    end

    always_comb begin
        dec_digit = 4'd0;
        dec_op    = calc_pkg::OP_NONE;
        dec_equal = 1'b0;
        dec_blank = 1'b0;
        case (key_idx)
            4'd0, 4'd1, 4'd2:    dec_digit = key_idx + 4'd1;    // 1 2 3
            4'd4, 4'd5, 4'd6:    dec_digit = key_idx;           // 4 5 6
            4'd8, 4'd9, 4'd10:   dec_digit = key_idx - 4'd1;    // 7 8 9
            4'd13:               dec_digit = 4'd0;
            4'd3:                dec_op    = calc_pkg::OP_ADD;
            4'd7:                dec_op    = calc_pkg::OP_SUB;
            4'd11:               dec_op    = calc_pkg::OP_MUL;
            calc_pkg::KEY_EQUAL: dec_equal = 1'b1;
            calc_pkg::KEY_NEG:   dec_op    = calc_pkg::OP_NEG;
            default:             dec_blank = 1'b1;              // key 14
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            SCAN: begin
                if (any_low) next_state = WAIT_STABLE;      // hold column
            end
            WAIT_STABLE: begin
                if (steady) next_state = any_low ? CONFIRM : SCAN;  // high = glitch
            end
            CONFIRM: begin
                next_state = dec_blank ? WAIT_RELEASE : WAIT_EVENT;
            end
            WAIT_EVENT: begin
                if (ev.key_read) next_state = WAIT_RELEASE;
            end
            WAIT_RELEASE: begin
                if (steady && !any_low) next_state = SCAN;  // released long enough
            end
            default: next_state = SCAN;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state         <= SCAN;
            col_index     <= '0;        // column 0 low after reset
            ev.read_input <= 1'b0;
        end else begin
            state <= next_state;
            if ((state == SCAN) && !any_low) begin
                col_index <= (col_index == COL_W'(calc_pkg::NUM_COLS - 1)) ?
                             '0 : col_index + 1'b1;
            end
            if ((state == CONFIRM) && !dec_blank) begin
                ev.read_input <= 1'b1;  // fields land on the same edge
            end else if ((state == WAIT_EVENT) && ev.key_read) begin
                ev.read_input <= 1'b0;
            end
        end
    end

    // event fields, held steady while read_input is up
    always_ff @(posedge clk) begin
        if (state == CONFIRM) begin
            ev.keypad_input   <= dec_digit;
            ev.operator_input <= dec_op;
            ev.equal_input    <= dec_equal;
        end
    end

endmodule

// File: verilog/debounce_timer.sv
`timescale 1ns/10ps

module debounce_timer #(
    parameter int DEBOUNCE_CYCLES = 10
) (
    input  logic clk,
    input  logic nRST,
    input  logic clear,         // restart count, resample level
    input  logic level,         // any row low
    output logic steady         // level unchanged for DEBOUNCE_CYCLES
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] count;        // saturating steady count
    logic             last_level;   // level seen at previous edge

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count      <= '0;
            last_level <= 1'b0;     // no key down after reset
        end else if (clear || (level != last_level)) begin
            count      <= '0;       // bounce or new phase restarts
            last_level <= level;
        end else if (count != CNT_W'(DEBOUNCE_CYCLES)) begin
            count      <= count + 1'b1;
        end
    end

    // level compare keeps a fresh edge from reading a stale full count
    assign steady = (count == CNT_W'(DEBOUNCE_CYCLES)) && (level == last_level);

endmodule

// File: verilog/key_event_if.sv
`timescale 1ns/10ps

interface key_event_if;

    logic          read_input;      // event pending, scanner side
    logic          key_read;        // one-cycle take strobe, controller side
    logic [3:0]    keypad_input;    // digit 0..9
    calc_pkg::op_t operator_input;  // OP_NONE for digits
    logic          equal_input;     // equal key

    modport scanner (
        output read_input,
        output keypad_input,
        output operator_input,
        output equal_input,
        input  key_read
    );

    modport controller (
        input  read_input,
        input  keypad_input,
        input  operator_input,
        input  equal_input,
        output key_read
    );

endinterface

// File: verilog/calc_pkg.sv
package calc_pkg;

    // keypad matrix size
    parameter int NUM_ROWS = 4;             // rows, pulled up, read by scanner
    parameter int NUM_COLS = 4;             // columns, one driven low at a time

    // operator code carried with each key event
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,                     // plain digit event
        OP_NEG  = 3'd1,                     // sign change of entry
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // key index is row * NUM_COLS + col
    parameter logic [3:0] KEY_EQUAL = 4'd12;   // equal flag
    parameter logic [3:0] KEY_BLANK = 4'd14;   // no meaning, raises nothing
    parameter logic [3:0] KEY_NEG   = 4'd15;   // sign change

endpackage
